// File: am_lock_pkg.sv
// Shared constants, types and the marker table for the AM lock lane block.
// The marker table holds the 100G lane encodings for lanes 0 to 19, M0M1M2 then M4M5M6.
// M4 to M6 are the bitwise complement of M0 to M2. BIP3 and BIP7 are not part of the table.
// The block overlay assumes the sync header sits in the two top bits of a 66-bit block.
`default_nettype none

package am_lock_pkg;

	localparam int NB_CODED_BLOCK = 66;	// coded block width
	localparam int NB_SH          = 2;	// sync header width
	localparam int NB_AM          = 48;	// compared marker bits, m0-m2 and m4-m6
	localparam int NB_BIP         = 8;	// bip3 / bip7 width
	localparam int MAX_ALIGNER    = 20;	// table size, one entry per pcs lane

	localparam logic [NB_SH-1:0] CTRL_SH         = 2'b10;	// control block header
	localparam logic [7:0]       BLOCK_TYPE_CTRL = 8'h1E;	// all-control block type
	localparam logic [6:0]       PCS_IDLE        = 7'h00;	// idle control char

	// replaces each locked marker in the output stream
	localparam logic [NB_CODED_BLOCK-1:0] IDLE_CTRL_BLOCK =
		{CTRL_SH, BLOCK_TYPE_CTRL, {8{PCS_IDLE}}};

	// overlay on a raw 66-bit block
	typedef struct packed {
		logic [NB_SH-1:0]   sh;	// sync header
		logic [NB_AM/2-1:0] m012;	// m0 m1 m2
		logic [NB_BIP-1:0]  bip3;	// received bip3
		logic [NB_AM/2-1:0] m456;	// m4 m5 m6, complement of m0-m2
		logic [NB_BIP-1:0]  bip7;	// complement of bip3
	} am_block_t;

	localparam logic [NB_AM-1:0] AM_TABLE [MAX_ALIGNER] = '{
		48'hC16821_3E97DE,	// lane 0
		48'h9D718E_628E71,	// lane 1
		48'h594BE8_A6B417,	// lane 2
		48'h4D957B_B26A84,	// lane 3
		48'hF50709_0AF8F6,	// lane 4
		48'hDD14C2_22EB3D,	// lane 5
		48'h9A4A26_65B5D9,	// lane 6
		48'h7B4566_84BA99,	// lane 7
		48'hA02476_5FDB89,	// lane 8
		48'h68C9FB_973604,	// lane 9
		48'hFD6C99_029366,	// lane 10
		48'hB99155_466EAA,	// lane 11
		48'h5CB9B2_A3464D,	// lane 12
		48'h1AF8BD_E50742,	// lane 13
		48'h83C7CA_7C3835,	// lane 14
		48'h3536CD_CAC932,	// lane 15
		48'hC4314C_3BCEB3,	// lane 16
		48'hADD6B7_522948,	// lane 17
		48'h5F662A_A099D5,	// lane 18
		48'hC0F0E5_3F0F1A	// lane 19
	};

	// st_count acquires, st_locked holds lock, st_check is locked with bad markers pending
	typedef enum logic [1:0] {
		st_search = 2'd0,	// hunting any lane encoding
		st_count  = 2'd1,	// lane captured, counting good markers
		st_check  = 2'd2,	// locked, one or more bad markers in a row
		st_locked = 2'd3	// locked, last marker good
	} lock_state_e;

	// fsm to comparator
	typedef struct packed {
		logic [MAX_ALIGNER-1:0] match_mask;	// one-hot captured lane
		logic                   enable_mask;	// compare only against captured lane
	} lock_ctrl_t;

	// fsm to top and bip checker, valid for the current input block
	typedef struct packed {
		logic am_lock;	// lock after this block
		logic start_of_lane;	// good marker in lock, replace with idle
		logic resync;	// lock lost on this block
		logic am_seen;	// marker position judged while locked
	} lock_event_t;

endpackage

`default_nettype wire

// File: am_lock_comparator.sv
// Combinational marker match against the lane table.
// N_ALIGNER must not exceed am_lock_pkg::MAX_ALIGNER.
// The compare mask is fixed to all ones, so every marker bit takes part.
`timescale 1ns/1ns
`default_nettype none

module am_lock_comparator
#(
	parameter int N_ALIGNER = 20	// lanes searched
)
(
	input  wire logic [am_lock_pkg::NB_AM-1:0] i_am_value,	// m0-m2, m4-m6 of current block
	input  wire am_lock_pkg::lock_ctrl_t       i_ctrl,	// lane mask from fsm
	output logic [N_ALIGNER-1:0]               o_match_vector,	// one bit per lane
	output logic                               o_am_match	// marker accepted
);

	import am_lock_pkg::*;

	localparam logic [NB_AM-1:0] COMPARE_MASK = '1;	// all bits compared

	logic [N_ALIGNER-1:0] lane_mask;	// captured lane, trimmed to N_ALIGNER
	logic [N_ALIGNER-1:0] masked_vector;	// match restricted to captured lane
	logic                 any_match;
	logic                 lane_match;

	// one equality check per lane encoding
	always_comb
	begin
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			o_match_vector[i] = ~|((i_am_value ^ AM_TABLE[i]) & COMPARE_MASK);
		end
	end

	assign lane_mask     = i_ctrl.match_mask[N_ALIGNER-1:0];
	assign masked_vector = o_match_vector & lane_mask;

	assign any_match  = |o_match_vector;	// search mode
	assign lane_match = |masked_vector;	// lock and acquire modes

	// once a lane is captured only its own encoding counts as good
	assign o_am_match = i_ctrl.enable_mask ? lane_match : any_match;

endmodule

`default_nettype wire

// File: am_lock_fsm.sv
// Search, acquire and loss FSM for one lane's alignment marker.
// Acts only on edges with i_enable, i_valid and i_block_lock high.
// The marker that starts acquisition is not counted. Lock is set by the judged marker
// that brings the valid count up to i_lock_thr, and that marker is already a start of lane.
// Lock is lost on the i_unlock_thr-th bad marker in a row. Event outputs are combinational
// and describe the current block, the top registers them.
`timescale 1ns/1ns
`default_nettype none

module am_lock_fsm
#(
	parameter  int N_ALIGNER  = 20,	// lanes searched
	parameter  int N_BLOCKS   = 16384,	// marker period incl. marker
	parameter  int MAX_VAL_AM = 20,	// top of lock threshold range
	parameter  int MAX_INV_AM = 8,	// top of unlock threshold range
	localparam int NB_VAL_AM  = $clog2(MAX_VAL_AM + 1),
	localparam int NB_INV_AM  = $clog2(MAX_INV_AM + 1)
)
(
	input  wire logic                   i_clock,
	input  wire logic                   i_rst_n,
	input  wire logic                   i_enable,
	input  wire logic                   i_valid,
	input  wire logic                   i_block_lock,	// from block sync
	input  wire logic                   i_am_match,	// from comparator
	input  wire logic [N_ALIGNER-1:0]   i_match_vector,	// from comparator
	input  wire logic [NB_VAL_AM-1:0]   i_lock_thr,	// good markers to lock
	input  wire logic [NB_INV_AM-1:0]   i_unlock_thr,	// bad markers to unlock
	output am_lock_pkg::lock_ctrl_t     o_ctrl,	// to comparator
	output am_lock_pkg::lock_event_t    o_event	// to top and bip checker
);

	import am_lock_pkg::*;

	localparam int                NB_TIMER   = $clog2(N_BLOCKS);
	localparam logic [NB_TIMER-1:0] TIMER_LAST = NB_TIMER'(N_BLOCKS - 1);

	lock_state_e            state, state_n;
	logic [NB_TIMER-1:0]    timer, timer_n;	// valid blocks since last marker
	logic [NB_VAL_AM-1:0]   val_cnt, val_cnt_n;	// good markers while acquiring
	logic [NB_INV_AM-1:0]   inv_cnt, inv_cnt_n;	// bad markers in a row while locked
	logic [MAX_ALIGNER-1:0] match_mask, match_mask_n;	// captured lane, one-hot
	logic                   marker_pos;	// current block sits at marker position
	logic                   locked;	// current state holds lock

	assign marker_pos = (timer == TIMER_LAST);
	assign locked     = (state == st_locked) || (state == st_check);

	always_comb
	begin
		state_n      = state;
		timer_n      = timer;
		val_cnt_n    = val_cnt;
		inv_cnt_n    = inv_cnt;
		match_mask_n = match_mask;
		o_event      = '0;
		if (!i_enable || !i_block_lock)
		begin
			state_n      = st_search;	// drop everything, no resync pulse
			timer_n      = '0;
			val_cnt_n    = '0;
			inv_cnt_n    = '0;
			match_mask_n = '0;
		end
		else if (i_valid)
		begin
			if (state == st_search)
			begin
				if (i_am_match)
				begin
					state_n                       = st_count;	// candidate lane found
					timer_n                       = '0;
					val_cnt_n                     = '0;
					match_mask_n                  = '0;
					match_mask_n[N_ALIGNER-1:0]   = i_match_vector;
				end
			end
			else if (!marker_pos)
			begin
				timer_n = timer + 1'b1;	// between markers
			end
			else
			begin
				timer_n         = '0;	// judge this block
				o_event.am_seen = locked;
				if (i_am_match)
				begin
					inv_cnt_n = '0;
					if (locked)
						state_n = st_locked;	// recovers from st_check too
					else
					begin
						val_cnt_n = val_cnt + 1'b1;
						if (val_cnt_n >= i_lock_thr)
							state_n = st_locked;
					end
					o_event.start_of_lane = (state_n == st_locked);
				end
				else if (!locked)
				begin
					state_n      = st_search;	// acquisition failed
					val_cnt_n    = '0;
					match_mask_n = '0;
				end
				else
				begin
					inv_cnt_n = inv_cnt + 1'b1;
					if (inv_cnt_n >= i_unlock_thr)
					begin
						state_n        = st_search;	// lock lost
						val_cnt_n      = '0;
						inv_cnt_n      = '0;
						match_mask_n   = '0;
						o_event.resync = 1'b1;
					end
					else
						state_n = st_check;
				end
			end
		end
		o_event.am_lock = (state_n == st_locked) || (state_n == st_check);
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state      <= st_search;
			timer      <= '0;
			val_cnt    <= '0;
			inv_cnt    <= '0;
			match_mask <= '0;
		end
		else
		begin
			state      <= state_n;
			timer      <= timer_n;
			val_cnt    <= val_cnt_n;
			inv_cnt    <= inv_cnt_n;
			match_mask <= match_mask_n;
		end
	end

	// outside search only the captured lane is accepted
	assign o_ctrl = '{match_mask: match_mask, enable_mask: (state != st_search)};

endmodule

`default_nettype wire

// File: am_bip_checker.sv
// Running BIP3 over the 64 payload bits of every valid block, sync header excluded.
// Bit k is the XOR of payload bits k, k+8, ... k+56, from the previous marker on,
// that marker included. Checked on each marker position judged in lock, absent or not.
// The accumulator restarts at each checked marker and at the marker that sets lock.
// The error counter saturates and clears only on reset.
`timescale 1ns/1ns
`default_nettype none

module am_bip_checker
#(
	parameter int NB_ERROR_COUNTER = 32
)
(
	input  wire logic                     i_clock,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_valid,
	input  wire logic                     i_enable,
	input  wire am_lock_pkg::am_block_t   i_data,	// current block
	input  wire am_lock_pkg::lock_event_t i_event,	// from fsm
	output logic [NB_ERROR_COUNTER-1:0]   o_error_counter
);

	import am_lock_pkg::*;

	localparam int NB_PAYLOAD = NB_CODED_BLOCK - NB_SH;
	localparam int N_LANES    = NB_PAYLOAD / NB_BIP;	// byte lanes folded together

	logic [NB_BIP-1:0]           bip_acc;	// parity since last marker
	logic [NB_BIP-1:0]           block_bip;	// parity of current block
	logic [NB_ERROR_COUNTER-1:0] err_cnt;
	logic                        bip_error;
	logic                        restart;	// reload from current block

	function automatic logic [NB_BIP-1:0] fold_payload(input am_block_t blk);
		logic [NB_PAYLOAD-1:0] payload;
		logic [NB_BIP-1:0]     acc;
		payload = {blk.m012, blk.bip3, blk.m456, blk.bip7};
		acc     = '0;
		for (int i = 0; i < N_LANES; i++)
		begin
			acc = acc ^ payload[i*NB_BIP +: NB_BIP];
		end
		return acc;
	endfunction

	assign block_bip = fold_payload(i_data);
	assign restart   = i_event.am_seen || i_event.start_of_lane;
	assign bip_error = i_event.am_seen && (bip_acc != i_data.bip3);	// current marker excluded

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			bip_acc <= '0;
			err_cnt <= '0;
		end
		else if (!i_enable)
			bip_acc <= '0;	// counter keeps its value
		else if (i_valid)
		begin
			if (restart)
				bip_acc <= block_bip;	// marker opens next period
			else
				bip_acc <= bip_acc ^ block_bip;
			if (bip_error && (err_cnt != '1))
				err_cnt <= err_cnt + 1'b1;	// saturating
		end
	end

	assign o_error_counter = err_cnt;

endmodule

`default_nettype wire

// File: am_lock_module.sv
// Alignment marker lock for one PCS receive lane, input already block locked.
// Outputs are registered on each valid block and hold between valid blocks,
// except o_start_of_lane and o_resync, which are one clock pulses.
// o_data passes every valid block, also with i_enable or i_block_lock low.
// o_lane_id shows the captured lane and is only meaningful while o_am_lock is high.
// Thresholds of zero lock or unlock on the first judged marker.
`timescale 1ns/1ns
`default_nettype none

module am_lock_module
#(
	parameter  int N_ALIGNER        = 20,	// lanes searched, at most 20
	parameter  int N_BLOCKS         = 16384,	// marker period incl. marker
	parameter  int MAX_VAL_AM       = 20,
	parameter  int MAX_INV_AM       = 8,
	parameter  int NB_ERROR_COUNTER = 32,
	localparam int NB_LANE_ID       = $clog2(N_ALIGNER),
	localparam int NB_VAL_AM        = $clog2(MAX_VAL_AM + 1),
	localparam int NB_INV_AM        = $clog2(MAX_INV_AM + 1)
)
(
	input  wire logic                                     i_clock,
	input  wire logic                                     i_rst_n,
	input  wire logic                                     i_enable,
	input  wire logic                                     i_valid,	// one strobe per block
	input  wire logic                                     i_block_lock,
	input  wire logic [am_lock_pkg::NB_CODED_BLOCK-1:0]   i_data,
	input  wire logic [NB_INV_AM-1:0]                     i_invalid_am_thr,
	input  wire logic [NB_VAL_AM-1:0]                     i_valid_am_thr,
	output logic [am_lock_pkg::NB_CODED_BLOCK-1:0]        o_data,	// to deskew
	output logic [NB_LANE_ID-1:0]                         o_lane_id,	// to reorder
	output logic [NB_ERROR_COUNTER-1:0]                   o_error_counter,
	output logic                                          o_am_lock,
	output logic                                          o_resync,
	output logic                                          o_start_of_lane
);

	import am_lock_pkg::*;

	am_block_t              in_block;	// field view of i_data
	logic [NB_AM-1:0]       am_value;
	logic [N_ALIGNER-1:0]   match_vector;
	logic                   am_match;
	lock_ctrl_t             ctrl;
	lock_event_t            evt;
	logic [NB_LANE_ID-1:0]  lane_enc;	// index of captured lane

	assign in_block = i_data;
	assign am_value = {in_block.m012, in_block.m456};	// bip fields not compared

	// one-hot to index, mask is zero or one-hot
	always_comb
	begin
		lane_enc = '0;
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			if (ctrl.match_mask[i])
				lane_enc = NB_LANE_ID'(i);
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_data          <= '0;
			o_lane_id       <= '0;
			o_am_lock       <= 1'b0;
			o_resync        <= 1'b0;
			o_start_of_lane <= 1'b0;
		end
		else if (i_valid)
		begin
			o_data          <= evt.start_of_lane ? IDLE_CTRL_BLOCK : i_data;	// marker -> idles
			o_lane_id       <= lane_enc;
			o_am_lock       <= evt.am_lock;
			o_resync        <= evt.resync;
			o_start_of_lane <= evt.start_of_lane;
		end
		else
		begin
			o_resync        <= 1'b0;	// pulses last one clock
			o_start_of_lane <= 1'b0;
		end
	end

	am_lock_comparator
	#(
		.N_ALIGNER (N_ALIGNER)
	)
	u_am_lock_comparator
	(
		.i_am_value     (am_value),
		.i_ctrl         (ctrl),
		.o_match_vector (match_vector),
		.o_am_match     (am_match)
	);

	am_lock_fsm
	#(
		.N_ALIGNER  (N_ALIGNER),
		.N_BLOCKS   (N_BLOCKS),
		.MAX_VAL_AM (MAX_VAL_AM),
		.MAX_INV_AM (MAX_INV_AM)
	)
	u_am_lock_fsm
	(
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_enable       (i_enable),
		.i_valid        (i_valid),
		.i_block_lock   (i_block_lock),
		.i_am_match     (am_match),
		.i_match_vector (match_vector),
		.i_lock_thr     (i_valid_am_thr),
		.i_unlock_thr   (i_invalid_am_thr),
		.o_ctrl         (ctrl),
		.o_event        (evt)
	);

	am_bip_checker
	#(
		.NB_ERROR_COUNTER (NB_ERROR_COUNTER)
	)
	u_am_bip_checker
	(
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_valid         (i_valid),
		.i_enable        (i_enable),
		.i_data          (in_block),
		.i_event         (evt),
		.o_error_counter (o_error_counter)	// updates with the marker's output
	);

endmodule

`default_nettype wire

// File: tb_am_lock_assert.sv
// Concurrent checks on the lock FSM events, bound into every am_lock_fsm instance.
// Events are combinational and sampled on every rising edge, valid or not.
`timescale 1ns/1ns
`default_nettype none

module am_lock_fsm_assert
(
	input wire logic                     i_clock,
	input wire logic                     i_rst_n,
	input wire logic [1:0]               i_state,	// fsm state register
	input wire am_lock_pkg::lock_event_t i_event
);

	import am_lock_pkg::*;

	int fail_cnt = 0;

	// resync sends the fsm to search, so it can't repeat
	resync_one_clock: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_event.resync |=> !i_event.resync)
	else
	begin
		$error("resync event held for more than one clock");
		fail_cnt++;
	end

	sol_needs_lock: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_event.start_of_lane |-> i_event.am_lock)
	else
	begin
		$error("start of lane without lock");
		fail_cnt++;
	end

	no_lock_in_search: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_state == st_search) |-> !i_event.am_lock)
	else
	begin
		$error("lock raised straight out of search");
		fail_cnt++;
	end

endmodule

bind am_lock_fsm am_lock_fsm_assert u_fsm_assert
(
	.i_clock (i_clock),
	.i_rst_n (i_rst_n),
	.i_state (state),
	.i_event (o_event)
);

`default_nettype wire

// File: tb_am_lock.sv
// Testbench for the AM lock block on one lane with a 20-lane table and a 16-block marker period.
// Expected outputs come from a block by block reference model of the lock and BIP3 rules.
// Payload comes from an LFSR. Each marker carries the BIP3 of the transmitted stream.
// Thresholds stay at 3 good and 4 bad markers for the whole run.
// Gaps in i_valid are only inserted in the last test.
`timescale 1ns/1ns
`default_nettype none

module tb_am_lock;

	import am_lock_pkg::*;

	localparam int N_BLOCKS     = 16;	// short marker period
	localparam int N_LANES      = 20;
	localparam int CLK_PERIOD   = 4;
	localparam int VALID_THR    = 3;
	localparam int INVALID_THR  = 4;
	localparam int MAX_GAP      = 3;	// two random bits per gap
	localparam int TOTAL_BLOCKS = 65 * N_BLOCKS + 8;	// 65 periods plus single blocks
	localparam int TIMEOUT_NS   = TOTAL_BLOCKS * (1 + MAX_GAP) * CLK_PERIOD + 1000;
	localparam int GOOD         = 0;
	localparam int BAD_BIP      = 1;
	localparam int ABSENT       = 2;	// data block at marker position

	// expected state after one valid block
	typedef struct packed {
		logic        hunting;	// no lane captured
		logic        locked;
		logic [4:0]  lane;	// captured lane
		logic [15:0] timer;	// valid blocks since last marker
		logic [4:0]  val;
		logic [3:0]  inv;
		logic [7:0]  acc;	// receive side bip3
		logic [31:0] err;
		logic [65:0] data;	// expected o_data
		logic        sol;
		logic        resync;
	} model_t;

	logic        i_clock;
	logic        i_rst_n;
	logic        i_enable;
	logic        i_valid;
	logic        i_block_lock;
	logic [65:0] i_data;
	logic [3:0]  i_invalid_am_thr;
	logic [4:0]  i_valid_am_thr;
	logic [65:0] o_data;
	logic [4:0]  o_lane_id;
	logic [31:0] o_error_counter;
	logic        o_am_lock;
	logic        o_resync;
	logic        o_start_of_lane;

	model_t      mdl;
	model_t      exp_q [$];	// one entry per valid block in flight
	logic [31:0] lfsr;
	logic [7:0]  tx_bip;	// transmit side bip3 since last marker
	logic        use_gaps;
	logic [31:0] err0;
	string       cur_test;
	int          checks, errors, tests, test_checks, test_errs;
	int          resync_cnt, sol_cnt;
	int          sweep_lanes [4] = '{0, 19, 12, 7};	// later tests rely on lane 7 coming last

	am_lock_module
	#(
		.N_ALIGNER (N_LANES),
		.N_BLOCKS  (N_BLOCKS)
	)
	uut
	(
		.i_clock          (i_clock),
		.i_rst_n          (i_rst_n),
		.i_enable         (i_enable),
		.i_valid          (i_valid),
		.i_block_lock     (i_block_lock),
		.i_data           (i_data),
		.i_invalid_am_thr (i_invalid_am_thr),
		.i_valid_am_thr   (i_valid_am_thr),
		.o_data           (o_data),
		.o_lane_id        (o_lane_id),
		.o_error_counter  (o_error_counter),
		.o_am_lock        (o_am_lock),
		.o_resync         (o_resync),
		.o_start_of_lane  (o_start_of_lane)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	// right shifting galois lfsr for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			r    = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	// bit k = xor of payload bits k, k+8 ... k+56
	function automatic logic [7:0] fold_bytes(input logic [63:0] p);
		logic [7:0] f;
		f = '0;
		for (int i = 0; i < 8; i++)
			f = f ^ p[i*8 +: 8];
		return f;
	endfunction

	function automatic int lane_of(input logic [65:0] blk);
		int hit;
		hit = -1;
		for (int i = 0; i < N_LANES; i++)
		begin
			if ({blk[63:40], blk[31:8]} == AM_TABLE[i])
				hit = i;
		end
		return hit;
	endfunction

	// reference model called once per valid block
	function automatic model_t model_next(input model_t m, input logic [65:0] blk,
		input logic en, input logic bl);
		model_t n;
		int     hit;
		logic   at_marker;
		logic   judged;
		n         = m;
		n.sol     = 1'b0;
		n.resync  = 1'b0;
		hit       = lane_of(blk);
		at_marker = en && bl && !m.hunting && (m.timer == N_BLOCKS - 1);
		judged    = at_marker && m.locked;	// bip3 checked only in lock
		if (!en || !bl)
		begin
			n.hunting = 1'b1;	// silent drop without resync
			n.locked  = 1'b0;
			n.timer   = '0;
			n.val     = '0;
			n.inv     = '0;
		end
		else if (m.hunting)
		begin
			if (hit >= 0)
			begin
				n.hunting = 1'b0;	// capture is not counted
				n.timer   = '0;
				n.val     = '0;
				n.lane    = 5'(hit);
			end
		end
		else if (!at_marker)
			n.timer = m.timer + 1'b1;
		else
		begin
			n.timer = '0;
			if (hit == int'(m.lane))
			begin
				n.inv = '0;
				if (!m.locked)
				begin
					n.val    = m.val + 1'b1;
					n.locked = (int'(n.val) >= VALID_THR);
				end
				n.sol = n.locked;	// lock-setting marker already replaced
			end
			else if (m.locked && (int'(m.inv) + 1 < INVALID_THR))
				n.inv = m.inv + 1'b1;
			else
			begin
				n.hunting = 1'b1;
				n.locked  = 1'b0;
				n.val     = '0;
				n.inv     = '0;
				n.resync  = m.locked;	// only a lost lock pulses
			end
		end
		if (!en)
			n.acc = '0;
		else
		begin
			if (judged && (m.acc != blk[39:32]))
				n.err = m.err + 1'b1;
			if (judged || n.sol)
				n.acc = fold_bytes(blk[63:0]);	// marker opens next period
			else
				n.acc = m.acc ^ fold_bytes(blk[63:0]);
		end
		n.data = n.sol ? IDLE_CTRL_BLOCK : blk;
		return n;
	endfunction

	task automatic check_value(input string what, input logic [65:0] exp_v,
		input logic [65:0] act_v);
		checks++;
		test_checks++;
		assert (act_v === exp_v)
		else
		begin
			$display("ERR %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
			errors++;
			test_errs++;
		end
	endtask

	task automatic send_block(input logic [65:0] blk);
		int gap;
		mdl = model_next(mdl, blk, i_enable, i_block_lock);
		exp_q.push_back(mdl);
		i_data  = blk;
		i_valid = 1'b1;
		@(posedge i_clock);
		#1;
		i_valid = 1'b0;
		gap     = use_gaps ? int'(rand_bits(2)) : 0;
		repeat (gap)
		begin
			i_data = {2'b01, rand_bits(64)};	// must be ignored
			@(posedge i_clock);
			#1;
		end
	endtask

	task automatic send_data();
		logic [65:0] blk;
		blk = {2'b01, rand_bits(64)};
		send_block(blk);
		tx_bip = tx_bip ^ fold_bytes(blk[63:0]);
	endtask

	task automatic send_marker(input int lane, input logic bad_bip);
		logic [7:0]  bip;
		logic [65:0] blk;
		bip = tx_bip ^ (bad_bip ? 8'h5A : 8'h00);
		blk = {2'b10, AM_TABLE[lane][47:24], bip, AM_TABLE[lane][23:0], ~bip};
		send_block(blk);
		tx_bip = fold_bytes(blk[63:0]);	// transmitted marker starts the next bip
	endtask

	task automatic send_period(input int lane, input int kind);
		if (kind == ABSENT)
			send_data();
		else
			send_marker(lane, kind == BAD_BIP);
		repeat (N_BLOCKS - 1)
			send_data();
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errs   = 0;
	endtask

	task automatic end_test();
		repeat (2) @(posedge i_clock);	// let the compare process drain
		#1;
		tests++;
		$display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
	endtask

	// checks outputs at each falling edge against the last valid block
	initial
	begin : compare
		model_t e;
		model_t last;
		last = '0;
		forever
		begin
			@(posedge i_clock);
			if (i_valid)
			begin
				@(negedge i_clock);
				e = exp_q.pop_front();
				check_value("o_data", e.data, o_data);
				check_value("o_am_lock", 66'(e.locked), 66'(o_am_lock));
				check_value("o_start_of_lane", 66'(e.sol), 66'(o_start_of_lane));
				check_value("o_resync", 66'(e.resync), 66'(o_resync));
				check_value("o_error_counter", 66'(e.err), 66'(o_error_counter));
				if (e.locked)
					check_value("o_lane_id", 66'(e.lane), 66'(o_lane_id));
				if (o_resync)
					resync_cnt++;
				if (o_start_of_lane)
					sol_cnt++;
				last = e;
			end
			else if (i_rst_n)
			begin
				@(negedge i_clock);	// no valid block, outputs hold and pulses end
				check_value("held o_data", last.data, o_data);
				check_value("held o_am_lock", 66'(last.locked), 66'(o_am_lock));
				check_value("held o_error_counter", 66'(last.err), 66'(o_error_counter));
				check_value("o_start_of_lane in gap", '0, 66'(o_start_of_lane));
				check_value("o_resync in gap", '0, 66'(o_resync));
				if (last.locked)
					check_value("held o_lane_id", 66'(last.lane), 66'(o_lane_id));
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout, run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		i_rst_n          = 1'b0;
		i_enable         = 1'b0;
		i_valid          = 1'b0;
		i_block_lock     = 1'b0;
		i_data           = '0;
		i_valid_am_thr   = 5'(VALID_THR);
		i_invalid_am_thr = 4'(INVALID_THR);
		lfsr             = 32'hd40d_96ff;
		tx_bip           = '0;
		use_gaps         = 1'b0;
		mdl              = '0;
		mdl.hunting      = 1'b1;
		checks           = 0;
		errors           = 0;
		tests            = 0;
		resync_cnt       = 0;
		sol_cnt          = 0;
		repeat (8) @(posedge i_clock);
		#1;
		i_rst_n = 1'b1;

		start_test("reset");
		check_value("o_data", '0, o_data);
		check_value("o_am_lock", '0, 66'(o_am_lock));
		check_value("o_resync", '0, 66'(o_resync));
		check_value("o_start_of_lane", '0, 66'(o_start_of_lane));
		check_value("o_lane_id", '0, 66'(o_lane_id));
		check_value("o_error_counter", '0, 66'(o_error_counter));
		end_test();

		start_test("no_lock_when_off");
		i_block_lock = 1'b1;	// block locked but disabled
		repeat (3) send_period(7, GOOD);
		i_enable     = 1'b1;
		i_block_lock = 1'b0;	// enabled without block lock
		repeat (3) send_period(7, GOOD);
		check_value("o_am_lock", '0, 66'(o_am_lock));
		end_test();

		start_test("acquire_sweep");
		foreach (sweep_lanes[k])
		begin
			i_block_lock = 1'b0;	// back to search
			send_data();
			i_block_lock = 1'b1;
			repeat (5) send_period(sweep_lanes[k], GOOD);
			check_value("o_am_lock", 66'(1), 66'(o_am_lock));
			check_value("o_lane_id", 66'(sweep_lanes[k]), 66'(o_lane_id));
		end
		end_test();

		start_test("marker_replace");
		sol_cnt = 0;
		repeat (4) send_period(7, GOOD);
		check_value("start_of_lane pulses", 66'(4), 66'(sol_cnt));
		end_test();

		start_test("bip_errors");
		err0 = o_error_counter;
		send_period(7, GOOD);
		send_period(7, BAD_BIP);
		send_period(7, GOOD);
		send_period(7, BAD_BIP);
		send_period(7, BAD_BIP);
		send_period(7, GOOD);
		check_value("error count delta", 66'(3), 66'(o_error_counter - err0));
		end_test();

		start_test("lock_loss");
		resync_cnt = 0;
		send_period(3, GOOD);	// wrong lane
		send_period(7, ABSENT);
		send_period(3, GOOD);
		send_period(7, GOOD);	// resets the bad run
		check_value("o_am_lock", 66'(1), 66'(o_am_lock));
		check_value("resync pulses", '0, 66'(resync_cnt));
		repeat (4) send_period(7, ABSENT);
		check_value("o_am_lock", '0, 66'(o_am_lock));
		check_value("resync pulses", 66'(1), 66'(resync_cnt));
		repeat (5) send_period(7, GOOD);
		check_value("o_am_lock", 66'(1), 66'(o_am_lock));
		check_value("o_lane_id", 66'(7), 66'(o_lane_id));
		end_test();

		start_test("valid_gaps");
		use_gaps     = 1'b1;
		i_block_lock = 1'b0;
		send_data();
		i_block_lock = 1'b1;
		repeat (5) send_period(5, GOOD);
		check_value("o_am_lock", 66'(1), 66'(o_am_lock));
		check_value("o_lane_id", 66'(5), 66'(o_lane_id));
		err0 = o_error_counter;
		repeat (2) send_period(5, BAD_BIP);
		check_value("error count delta", 66'(2), 66'(o_error_counter - err0));
		repeat (4) send_period(5, ABSENT);
		check_value("o_am_lock", '0, 66'(o_am_lock));
		repeat (5) send_period(5, GOOD);
		check_value("o_am_lock", 66'(1), 66'(o_am_lock));
		use_gaps = 1'b0;
		end_test();

		if (exp_q.size() != 0)
		begin
			$display("compare process left %0d blocks unchecked", exp_q.size());
			errors++;
		end
		if (uut.u_am_lock_fsm.u_fsm_assert.fail_cnt != 0)
		begin
			$display("FSM assertions failed %0d times", uut.u_am_lock_fsm.u_fsm_assert.fail_cnt);
			errors += uut.u_am_lock_fsm.u_fsm_assert.fail_cnt;
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
am_lock_pkg.sv
am_lock_comparator.sv
am_lock_fsm.sv
am_bip_checker.sv
am_lock_module.sv
tb_am_lock_assert.sv
tb_am_lock.sv
